// ==== compile.f ====
src/pulse_meter_pkg.sv
src/pulse_timer.sv
src/bin_to_bcd.sv
src/report_formatter.sv
src/uart_tx.sv
src/pulse_meter_top.sv
tests/pulse_meter_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the pulse meter testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module pulse_meter_tb -f compile.f &&
sim_output=$(./obj_dir/Vpulse_meter_tb 2>&1) &&
echo "$sim_output" &&
echo "$sim_output" | grep -q "Simulation completed successfully" ||
{ echo "pulse meter run did not pass"; exit 1; }

// ==== tests/pulse_meter_tb.sv ====
// ******************************
// pulse meter testbench that drives trigger pulses
// and decodes the serial report lines
// ******************************

`timescale 1ns/1ns
`default_nettype none

module pulse_meter_tb;
	import pulse_meter_pkg::*;

	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int SEED = 29;
	localparam int IDLE_CYCLES = 200;
	localparam int QUIET_CYCLES = 300;
	localparam int FIRST_CHAR_WAIT = 200; // pulse end to first start bit
	localparam int SINGLE_WIDTH = 37;
	localparam int RANDOM_PULSES = 10;
	localparam int MAX_RANDOM_WIDTH = 600;
	localparam int FIRST_WIDTH = 60;
	localparam int BLOCKED_DELAY = 300; // well inside a line
	localparam int BLOCKED_WIDTH = 5;
	localparam int THIRD_WIDTH = 123;
	localparam int LONG_WIDTH = 70000;
	localparam int EXPECTED_LINES = 1 + RANDOM_PULSES + 2 + 1;
	localparam int LINE_CYCLES = LINE_LENGTH * 10 * CLOCKS_PER_BIT;
	localparam int PULSE_CYCLES = SINGLE_WIDTH + RANDOM_PULSES * MAX_RANDOM_WIDTH
		+ FIRST_WIDTH + BLOCKED_WIDTH + THIRD_WIDTH + LONG_WIDTH;
	localparam int WATCHDOG_CYCLES = 2 * (PULSE_CYCLES + EXPECTED_LINES * LINE_CYCLES
		+ RESET_CYCLES + IDLE_CYCLES + QUIET_CYCLES);

	logic clock;
	logic reset;
	logic trigger;
	logic tx;
	logic report_busy;

	int error_count;
	int tests_passed;
	int tests_failed;
	int pulses_ended; // expected pulse count

	pulse_meter_top uut (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.tx(tx),
		.report_busy(report_busy)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	task automatic compare_byte(string name, byte_t expected, byte_t actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected 0x%h actual 0x%h",
				$time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_level(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("MISMATCH at %0t ns: %s expected %b actual %b",
				$time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_error(string text);
		$display("ERROR at %0t ns: %s", $time, text);
		error_count++;
	endtask

	task automatic finish_test(string title, int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("%0t ns: %s passed", $time, title);
		end else begin
			tests_failed++;
			$display("%0t ns: %s failed with %0d errors", $time, title,
				error_count - errors_before);
		end
	endtask

	// ascii character expected at one position of a report line
	function automatic byte_t expected_char(int index, int count, int duration);
		int value;
		int place;
		value = 0;
		place = 0;
		if (index == DIGITS) return 8'h20;
		if (index == 2 * DIGITS + 1) return 8'h0d; // cr
		if (index == 2 * DIGITS + 2) return 8'h0a; // lf
		if (index < DIGITS) begin
			value = count % 65536; // count wraps at 16 bits
			place = DIGITS - 1 - index;
		end else begin
			value = duration;
			place = 2 * DIGITS - index;
		end
		repeat (place) value = value / 10;
		return byte_t'(8'h30 + value % 10);
	endfunction

	// trigger high for exactly width rising edges
	task automatic drive_pulse(int width);
		@(negedge clock);
		trigger = 1'b1;
		repeat (width) @(negedge clock);
		trigger = 1'b0;
		pulses_ended++;
	endtask

	// waits for a start bit, then samples each bit in its middle
	task automatic receive_char(int max_wait, output byte_t value, output bit found);
		int waited;
		waited = 0;
		value = '0;
		found = 1'b0;
		@(negedge clock);
		while (tx !== 1'b0 && waited < max_wait) begin
			@(negedge clock);
			waited++;
		end
		if (tx !== 1'b0) return;
		repeat (CLOCKS_PER_BIT / 2 - 1) @(negedge clock);
		compare_level("tx start bit", 1'b0, tx);
		for (int b = 0; b < 8; b++) begin
			repeat (CLOCKS_PER_BIT) @(negedge clock);
			value[b] = tx; // lsb first
		end
		repeat (CLOCKS_PER_BIT) @(negedge clock);
		compare_level("tx stop bit", 1'b1, tx);
		found = 1'b1;
	endtask

	task automatic receive_line(int count, int duration, int first_wait);
		byte_t received;
		bit found;
		int waited;
		for (int i = 0; i < LINE_LENGTH; i++) begin
			receive_char((i == 0) ? first_wait : 4 * CLOCKS_PER_BIT, received, found);
			if (!found) begin
				report_error($sformatf("no start bit seen for character %0d of the line", i));
				return;
			end
			compare_byte($sformatf("tx character %0d", i),
				expected_char(i, count, duration), received);
		end
		compare_level("report_busy", 1'b1, report_busy); // still inside the last stop bit
		waited = 0;
		while (report_busy === 1'b1 && waited < 2 * CLOCKS_PER_BIT) begin
			@(negedge clock);
			waited++;
		end
		compare_level("report_busy", 1'b0, report_busy);
	endtask

	// line idle and no report running
	task automatic check_quiet(int cycles);
		repeat (cycles) begin
			@(negedge clock);
			if (tx !== 1'b1 || report_busy !== 1'b0) begin
				compare_level("tx", 1'b1, tx);
				compare_level("report_busy", 1'b0, report_busy);
				break;
			end
		end
	endtask

	task automatic test_idle_after_reset();
		int errors_before;
		errors_before = error_count;
		check_quiet(IDLE_CYCLES);
		finish_test("idle after reset", errors_before);
	endtask

	task automatic test_single_pulse();
		int errors_before;
		errors_before = error_count;
		drive_pulse(SINGLE_WIDTH);
		receive_line(pulses_ended, SINGLE_WIDTH, FIRST_CHAR_WAIT);
		finish_test("single pulse", errors_before);
	endtask

	task automatic test_random_pulses();
		int errors_before;
		int width;
		errors_before = error_count;
		for (int n = 0; n < RANDOM_PULSES; n++) begin
			// a single high sample never forms the 110 end pattern
			width = $urandom_range(MAX_RANDOM_WIDTH, 2);
			drive_pulse(width);
			receive_line(pulses_ended, width, FIRST_CHAR_WAIT);
		end
		finish_test("random pulse widths", errors_before);
	endtask

	task automatic test_blocked_pulse();
		int errors_before;
		int reported;
		errors_before = error_count;
		drive_pulse(FIRST_WIDTH);
		reported = pulses_ended;
		fork
			receive_line(reported, FIRST_WIDTH, FIRST_CHAR_WAIT);
			begin
				while (report_busy !== 1'b1) @(negedge clock);
				repeat (BLOCKED_DELAY) @(negedge clock);
				drive_pulse(BLOCKED_WIDTH);
				compare_level("report_busy", 1'b1, report_busy); // ends mid line
			end
		join
		check_quiet(QUIET_CYCLES); // no line for the short pulse
		drive_pulse(THIRD_WIDTH);
		receive_line(reported + 2, THIRD_WIDTH, FIRST_CHAR_WAIT);
		finish_test("pulse during report", errors_before);
	endtask

	task automatic test_saturation();
		int errors_before;
		errors_before = error_count;
		drive_pulse(LONG_WIDTH);
		receive_line(pulses_ended, 65535, FIRST_CHAR_WAIT); // full scale
		finish_test("duration saturation", errors_before);
	endtask

	initial begin
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		pulses_ended = 0;
		reset = 1'b1;
		trigger = 1'b0;
		void'($urandom(SEED));
		repeat (RESET_CYCLES) @(negedge clock);
		reset = 1'b0;

		test_idle_after_reset();
		test_single_pulse();
		test_random_pulses();
		test_blocked_pulse();
		test_saturation();

		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/pulse_meter_top.sv ====
// ******************************
// pulse width meter with serial report
// ******************************

`timescale 1ns/1ns
`default_nettype none

module pulse_meter_top (
	input wire logic clock,
	input wire logic reset,
	input wire logic trigger,
	output logic tx,
	output logic report_busy
);
	import pulse_meter_pkg::*;

	logic pulse_end;
	count_t pulse_count;
	duration_t last_duration;

	count_t count_bin;
	duration_t duration_bin;
	logic convert;
	bcd_t count_digits;
	logic count_done;
	bcd_t duration_digits;
	logic duration_done;

	logic uart_busy;
	logic send;
	byte_t data;

	pulse_timer timer (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.pulse_end(pulse_end),
		.pulse_count(pulse_count),
		.last_duration(last_duration)
	);

	// count and duration share the same width
	bin_to_bcd count_conv (
		.clock(clock),
		.reset(reset),
		.convert(convert),
		.bin(count_bin),
		.digits(count_digits),
		.done(count_done)
	);

	bin_to_bcd duration_conv (
		.clock(clock),
		.reset(reset),
		.convert(convert),
		.bin(duration_bin),
		.digits(duration_digits),
		.done(duration_done)
	);

	report_formatter formatter (
		.clock(clock),
		.reset(reset),
		.pulse_end(pulse_end),
		.pulse_count(pulse_count),
		.last_duration(last_duration),
		.count_bin(count_bin),
		.duration_bin(duration_bin),
		.convert(convert),
		.count_digits(count_digits),
		.count_done(count_done),
		.duration_digits(duration_digits),
		.duration_done(duration_done),
		.uart_busy(uart_busy),
		.send(send),
		.data(data),
		.report_busy(report_busy)
	);

	uart_tx transmitter (
		.clock(clock),
		.reset(reset),
		.send(send),
		.data(data),
		.tx(tx),
		.busy(uart_busy)
	);

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
// ******************************
// 8N1 serial transmitter
// ******************************

`timescale 1ns/1ns
`default_nettype none

module uart_tx (
	input wire logic clock,
	input wire logic reset,
	input wire logic send,
	input wire pulse_meter_pkg::byte_t data,
	output logic tx,
	output logic busy
);
	import pulse_meter_pkg::*;

	logic [BIT_TIMER_WIDTH-1:0] bit_timer;
	logic [3:0] bit_index; // 0 is start, 9 is stop
	logic [9:0] frame; // bit 0 is on the line

	assign tx = frame[0];

	always_ff @(posedge clock) begin
		if (reset) begin
			frame <= '1; // idle line is high
			busy <= 1'b0;
			bit_timer <= '0;
			bit_index <= '0;
		end else if (!busy) begin
			if (send) begin
				frame <= {1'b1, data, 1'b0}; // stop, data lsb first, start
				busy <= 1'b1;
				bit_timer <= '0;
				bit_index <= '0;
			end
		end else begin
			if (bit_timer == BIT_TIMER_WIDTH'(CLOCKS_PER_BIT - 1)) begin
				bit_timer <= '0;
				frame <= {1'b1, frame[9:1]};
				if (bit_index == 4'd9) begin
					busy <= 1'b0; // end of stop bit
				end else begin
					bit_index <= bit_index + 1'b1;
				end
			end else begin
				bit_timer <= bit_timer + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/report_formatter.sv ====
// ******************************
// report formatter that converts count and duration
// and feeds one text line to the transmitter
// ******************************

`timescale 1ns/1ns
`default_nettype none

module report_formatter (
	input wire logic clock,
	input wire logic reset,
	input wire logic pulse_end,
	input wire pulse_meter_pkg::count_t pulse_count,
	input wire pulse_meter_pkg::duration_t last_duration,
	output pulse_meter_pkg::count_t count_bin,
	output pulse_meter_pkg::duration_t duration_bin,
	output logic convert,
	input wire pulse_meter_pkg::bcd_t count_digits,
	input wire logic count_done,
	input wire pulse_meter_pkg::bcd_t duration_digits,
	input wire logic duration_done,
	input wire logic uart_busy,
	output logic send,
	output pulse_meter_pkg::byte_t data,
	output logic report_busy
);
	import pulse_meter_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		CONVERTING,
		SENDING
	} state_t;

	state_t state;
	logic seen_count;
	logic seen_duration;
	logic [3:0] char_index; // next character to send

	// character at a given line position
	function automatic byte_t line_char(logic [3:0] index, bcd_t count_bcd, bcd_t duration_bcd);
		int position;
		logic [3:0] nibble;
		byte_t result;
		position = 0;
		nibble = 4'h0;
		if (int'(index) < DIGITS) begin
			position = DIGITS - 1 - int'(index);
			nibble = count_bcd[4*position +: 4];
			result = ASCII_ZERO + byte_t'(nibble);
		end else if (int'(index) == DIGITS) begin
			result = ASCII_SPACE;
		end else if (int'(index) <= 2*DIGITS) begin
			position = 2*DIGITS - int'(index); // index 6 is the top digit
			nibble = duration_bcd[4*position +: 4];
			result = ASCII_ZERO + byte_t'(nibble);
		end else if (int'(index) == 2*DIGITS + 1) begin
			result = ASCII_CR;
		end else begin
			result = ASCII_LF;
		end
		return result;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			convert <= 1'b0;
			send <= 1'b0;
			report_busy <= 1'b0;
			seen_count <= 1'b0;
			seen_duration <= 1'b0;
			char_index <= '0;
		end else begin
			convert <= 1'b0;
			send <= 1'b0;
			case (state)
				IDLE: begin
					if (pulse_end) begin
						convert <= 1'b1; // both converters at once
						report_busy <= 1'b1;
						seen_count <= 1'b0;
						seen_duration <= 1'b0;
						state <= CONVERTING;
					end
				end
				CONVERTING: begin
					if (count_done) seen_count <= 1'b1;
					if (duration_done) seen_duration <= 1'b1;
					if ((seen_count || count_done) && (seen_duration || duration_done)) begin
						char_index <= '0;
						state <= SENDING;
					end
				end
				SENDING: begin
					// send was high last cycle, so busy is not up yet
					if (!uart_busy && !send) begin
						if (char_index == 4'(LINE_LENGTH)) begin
							report_busy <= 1'b0; // last stop bit done
							state <= IDLE;
						end else begin
							send <= 1'b1;
							char_index <= char_index + 1'b1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// captured values and the outgoing character
	always_ff @(posedge clock) begin
		if (state == IDLE && pulse_end) begin
			count_bin <= pulse_count;
			duration_bin <= last_duration;
		end
		if (state == SENDING && !uart_busy && !send) begin
			data <= line_char(char_index, count_digits, duration_digits);
		end
	end

endmodule

`default_nettype wire

// ==== src/bin_to_bcd.sv ====
// ******************************
// binary to bcd by shift and add three
// ******************************

`timescale 1ns/1ns
`default_nettype none

module bin_to_bcd (
	input wire logic clock,
	input wire logic reset,
	input wire logic convert,
	input wire pulse_meter_pkg::duration_t bin,
	output pulse_meter_pkg::bcd_t digits,
	output logic done
);
	import pulse_meter_pkg::*;

	logic running;
	logic [4:0] step; // shifts done so far
	bcd_t work_bcd;
	duration_t work_bin;
	bcd_t adjusted;

	// add three to every digit of five or more
	function automatic bcd_t add_three(bcd_t value);
		bcd_t result;
		result = value;
		for (int d = 0; d < DIGITS; d++) begin
			if (value[4*d +: 4] >= 4'd5) begin
				result[4*d +: 4] = value[4*d +: 4] + 4'd3;
			end
		end
		return result;
	endfunction

	assign adjusted = add_three(work_bcd);

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (convert) begin
				running <= 1'b1;
				step <= '0;
			end else if (running) begin
				if (step == 5'(BIN_WIDTH)) begin
					running <= 1'b0; // publish below
					done <= 1'b1;
				end else begin
					step <= step + 1'b1;
				end
			end
		end
	end

	// shift register and published digits
	always_ff @(posedge clock) begin
		if (convert) begin
			work_bin <= bin;
			work_bcd <= '0;
		end else if (running) begin
			if (step == 5'(BIN_WIDTH)) begin
				digits <= work_bcd;
			end else begin
				{work_bcd, work_bin} <= {adjusted, work_bin} << 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/pulse_timer.sv ====
// ******************************
// pulse timer that synchronizes the trigger,
// times each high pulse and counts ended pulses
// ******************************

`timescale 1ns/1ns
`default_nettype none

module pulse_timer (
	input wire logic clock,
	input wire logic reset,
	input wire logic trigger, // asynchronous
	output logic pulse_end,
	output pulse_meter_pkg::count_t pulse_count,
	output pulse_meter_pkg::duration_t last_duration
);
	import pulse_meter_pkg::*;

	logic trigger_meta;
	logic trigger_sync;
	logic [2:0] history; // newest sample in bit 0
	duration_t live_duration;

	// two flop synchronizer
	always_ff @(posedge clock) begin
		if (reset) begin
			trigger_meta <= 1'b0;
			trigger_sync <= 1'b0;
		end else begin
			trigger_meta <= trigger;
			trigger_sync <= trigger_meta;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			history <= 3'b000;
		end else begin
			history <= {history[1:0], trigger_sync}; // 110 marks a falling end
		end
	end

	// live counter latched and cleared on a falling end
	always_ff @(posedge clock) begin
		if (reset) begin
			live_duration <= '0;
			last_duration <= '0;
			pulse_count <= '0;
			pulse_end <= 1'b0;
		end else begin
			pulse_end <= 1'b0;
			if (history == 3'b110) begin
				last_duration <= live_duration;
				live_duration <= '0;
				pulse_count <= pulse_count + 1'b1; // wraps
				pulse_end <= 1'b1;
			end else if (history[0]) begin
				if (live_duration != '1) begin // saturate at full scale
					live_duration <= live_duration + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/pulse_meter_pkg.sv ====
// ******************************
// pulse meter shared types and constants
// ******************************

`default_nettype none

package pulse_meter_pkg;

	// widths
	localparam int BIN_WIDTH = 16; // equal to the count and duration widths
	localparam int DIGITS = 5; // decimal digits per field
	localparam int LINE_LENGTH = 13; // 5 + space + 5 + cr + lf

	// serial bit period kept short for simulation
	localparam int CLOCKS_PER_BIT = 8;
	localparam int BIT_TIMER_WIDTH = $clog2(CLOCKS_PER_BIT);

	// report characters
	localparam logic [7:0] ASCII_ZERO = 8'h30;
	localparam logic [7:0] ASCII_SPACE = 8'h20;
	localparam logic [7:0] ASCII_CR = 8'h0d;
	localparam logic [7:0] ASCII_LF = 8'h0a;

	// ended pulses since reset with wraparound
	typedef logic [BIN_WIDTH-1:0] count_t;

	// saturating pulse length in clock cycles
	typedef logic [BIN_WIDTH-1:0] duration_t;

	// five bcd digits with the most significant in the top nibble
	typedef logic [4*DIGITS-1:0] bcd_t;

	// one serial character
	typedef logic [7:0] byte_t;

endpackage

`default_nettype wire
